// File: Makefile
.PHONY: run clean

run: obj_dir/Vtb_bus_fabric
	@out="$$(./obj_dir/Vtb_bus_fabric 2>&1)"; echo "$$out"; \
	    echo "$$out" | grep -qx 'PASS: all tests'

obj_dir/Vtb_bus_fabric: filelist.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns \
	    --top-module tb_bus_fabric -f filelist.f

clean:
	rm -rf obj_dir

// File: bus_exec.sv
`timescale 1ns/1ns

module bus_exec
    import bus_pkg::*;
    import map_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 s_valid,
    output logic                 s_ready,
    input  logic                 s_io,
    input  logic [addr_w-1:0]    s_addr,
    input  logic                 s_wr_en,
    input  logic [bytesel_w-1:0] s_bytesel,
    input  logic [data_w-1:0]    s_wdata,
    output logic                 e_valid,
    input  logic                 e_ready,
    output logic [data_w-1:0]    e_rdata,
    output logic                 main_en,
    output logic                 shadow_en_strobe,
    output logic                 ram_wr_en,
    output logic [main_aw-1:0]   ram_addr,
    output logic [bytesel_w-1:0] ram_bytesel,
    output logic [data_w-1:0]    ram_wdata,
    input  logic [data_w-1:0]    main_rdata,
    input  logic [data_w-1:0]    shadow_rdata,
    output logic                 io_en,
    output logic                 io_wr_en,
    output logic [addr_w-1:0]    io_addr,
    output logic [bytesel_w-1:0] io_bytesel,
    output logic [data_w-1:0]    io_wdata,
    input  logic [data_w-1:0]    io_rdata,
    input  logic                 shadow_en
);

    typedef enum logic [1:0] {sel_main, sel_shadow, sel_io} sel_t;

    logic accept;
    logic to_shadow;
    sel_t sel_q;
    logic wr_q;

    assign s_ready   = !e_valid || e_ready;
    assign accept    = s_valid && s_ready;
    assign to_shadow = !s_io && shadow_en && (s_addr >= shadow_base);  // Window ends at top

    assign main_en          = accept && !s_io && !to_shadow;
    assign shadow_en_strobe = accept && to_shadow;
    assign io_en            = accept && s_io;

    // Both RAMs share one address, main wraps modulo its depth
    assign ram_wr_en   = s_wr_en;
    assign ram_addr    = s_addr[main_aw-1:0];
    assign ram_bytesel = s_bytesel;
    assign ram_wdata   = s_wdata;

    assign io_wr_en   = s_wr_en;
    assign io_addr    = s_addr;
    assign io_bytesel = s_bytesel;
    assign io_wdata   = s_wdata;

    always_ff @(posedge clk) begin
        if (rst)
            e_valid <= 1'b0;
        else if (accept)
            e_valid <= 1'b1;
        else if (e_ready)
            e_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sel_q <= s_io ? sel_io : (to_shadow ? sel_shadow : sel_main);
            wr_q  <= s_wr_en;
        end
    end

    // Target data holds until the next strobe
    always_comb begin
        if (wr_q)
            e_rdata = '0;
        else begin
            case (sel_q)
                sel_shadow: e_rdata = shadow_rdata;
                sel_io:     e_rdata = io_rdata;
                default:    e_rdata = main_rdata;
            endcase
        end
    end

endmodule

// File: bus_fabric_asserts.sv
`timescale 1ns/1ns

module bus_fabric_asserts
    import bus_pkg::*;
(
    input logic                 clk,
    input logic                 rst,
    input logic                 req_valid,
    input logic                 req_ready,
    input logic                 req_io,
    input logic [addr_w-1:0]    req_addr,
    input logic                 req_wr_en,
    input logic [bytesel_w-1:0] req_bytesel,
    input logic [data_w-1:0]    req_wdata,
    input logic                 rsp_valid,
    input logic                 rsp_ready,
    input logic [data_w-1:0]    rsp_rdata
);

    req_held: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid &&
            $stable({req_io, req_addr, req_wr_en, req_bytesel, req_wdata}))
        else $error("Request fields changed while stalled");

    rsp_held: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else $error("Response dropped or changed before it was taken");

    rsp_quiet: assert property (@(posedge clk) rst |=> !rsp_valid)
        else $error("rsp_valid high during reset");

endmodule

bind bus_fabric_top bus_fabric_asserts u_asserts (
    .clk(clk), .rst(rst),
    .req_valid(req_valid), .req_ready(req_ready), .req_io(req_io),
    .req_addr(req_addr), .req_wr_en(req_wr_en), .req_bytesel(req_bytesel),
    .req_wdata(req_wdata),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata)
);

// File: bus_fabric_top.sv
`timescale 1ns/1ns

module bus_fabric_top
    import bus_pkg::*;
    import map_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  logic                 req_io,
    input  logic [addr_w-1:0]    req_addr,
    input  logic                 req_wr_en,
    input  logic [bytesel_w-1:0] req_bytesel,
    input  logic [data_w-1:0]    req_wdata,
    output logic                 rsp_valid,
    input  logic                 rsp_ready,
    output logic [data_w-1:0]    rsp_rdata
);

    bus_req_t req_in;
    bus_req_t req_out;
    bus_rsp_t rsp_in;
    bus_rsp_t rsp_out;

    logic                 s_valid;
    logic                 s_ready;
    logic                 e_valid;
    logic                 e_ready;
    logic [data_w-1:0]    e_rdata;
    logic                 main_en;
    logic                 shadow_en_strobe;
    logic                 ram_wr_en;
    logic [main_aw-1:0]   ram_addr;
    logic [bytesel_w-1:0] ram_bytesel;
    logic [data_w-1:0]    ram_wdata;
    logic [data_w-1:0]    main_rdata;
    logic [data_w-1:0]    shadow_rdata;
    logic                 io_en;
    logic                 io_wr_en;
    logic [addr_w-1:0]    io_addr;
    logic [bytesel_w-1:0] io_bytesel;
    logic [data_w-1:0]    io_wdata;
    logic [data_w-1:0]    io_rdata;
    logic                 shadow_en;

    assign req_in    = '{io: req_io, addr: req_addr, wr_en: req_wr_en,
                         bytesel: req_bytesel, wdata: req_wdata};
    assign rsp_in    = '{rdata: e_rdata};
    assign rsp_rdata = rsp_out.rdata;

    pipe_reg #(.payload_t(bus_req_t)) u_req_slice (
        .clk(clk), .rst(rst),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req_in),
        .out_valid(s_valid), .out_ready(s_ready), .out_data(req_out)
    );

    bus_exec u_exec (
        .clk(clk), .rst(rst),
        .s_valid(s_valid), .s_ready(s_ready),
        .s_io(req_out.io), .s_addr(req_out.addr), .s_wr_en(req_out.wr_en),
        .s_bytesel(req_out.bytesel), .s_wdata(req_out.wdata),
        .e_valid(e_valid), .e_ready(e_ready), .e_rdata(e_rdata),
        .main_en(main_en), .shadow_en_strobe(shadow_en_strobe),
        .ram_wr_en(ram_wr_en), .ram_addr(ram_addr),
        .ram_bytesel(ram_bytesel), .ram_wdata(ram_wdata),
        .main_rdata(main_rdata), .shadow_rdata(shadow_rdata),
        .io_en(io_en), .io_wr_en(io_wr_en), .io_addr(io_addr),
        .io_bytesel(io_bytesel), .io_wdata(io_wdata),
        .io_rdata(io_rdata), .shadow_en(shadow_en)
    );

    mem_ram #(.depth(main_words)) u_main_ram (
        .clk(clk), .en(main_en), .wr_en(ram_wr_en), .addr(ram_addr),
        .bytesel(ram_bytesel), .wdata(ram_wdata), .rdata(main_rdata)
    );

    mem_ram #(.depth(shadow_words)) u_shadow_ram (
        .clk(clk), .en(shadow_en_strobe), .wr_en(ram_wr_en),
        .addr(ram_addr[shadow_aw-1:0]),  // Offset within window
        .bytesel(ram_bytesel), .wdata(ram_wdata), .rdata(shadow_rdata)
    );

    io_regs u_io_regs (
        .clk(clk), .rst(rst), .en(io_en), .wr_en(io_wr_en), .addr(io_addr),
        .bytesel(io_bytesel), .wdata(io_wdata), .rdata(io_rdata),
        .shadow_en(shadow_en)
    );

    pipe_reg #(.payload_t(bus_rsp_t)) u_rsp_slice (
        .clk(clk), .rst(rst),
        .in_valid(e_valid), .in_ready(e_ready), .in_data(rsp_in),
        .out_valid(rsp_valid), .out_ready(rsp_ready), .out_data(rsp_out)
    );

endmodule

// File: bus_pkg.sv
package bus_pkg;

    localparam int data_w    = 16;
    localparam int addr_w    = 19;  // Word address
    localparam int bytesel_w = 2;

    // Request as carried through the request slice
    typedef struct packed {
        logic                 io;
        logic [addr_w-1:0]    addr;
        logic                 wr_en;
        logic [bytesel_w-1:0] bytesel;
        logic [data_w-1:0]    wdata;
    } bus_req_t;

    // Response as carried through the response slice
    typedef struct packed {
        logic [data_w-1:0] rdata;
    } bus_rsp_t;

endpackage

// File: bus_testdata.txt
# io wr addr  bs wdata expect   (hex, one request per line)
# expect is the response read data, zero for writes
0 1 00010 3 1234 0000
0 0 00010 0 0000 1234
0 1 04020 3 abcd 0000   # wraps to word 00020
0 0 00020 0 0000 abcd
0 0 0c020 0 0000 abcd
# byte lanes
0 1 00030 1 1155 0000
0 0 00030 0 0000 0055
0 1 00030 2 66ff 0000
0 0 00030 0 0000 6655
# io registers
1 0 07ffe 0 0000 0000
1 1 07ffe 3 beef 0000
1 0 07ffe 0 0000 beef
1 1 07ffe 2 12ff 0000
1 0 07ffe 0 0000 12ef
1 1 07ff6 3 fffe 0000
1 0 07ff6 0 0000 0000
1 1 07ff0 3 5a5a 0000
1 0 07ff0 0 0000 0000
1 0 07ffe 0 0000 12ef
# shadow window
0 1 7f000 3 c0de 0000
0 1 7ffff 3 f00d 0000
0 0 7f000 0 0000 c0de
1 1 07ff6 3 ffff 0000
1 0 07ff6 0 0000 0001
0 0 7f000 0 0000 0000
0 0 7ffff 0 0000 0000
0 1 7f000 3 5151 0000
0 1 7ffff 1 00aa 0000
0 0 7f000 0 0000 5151
0 0 7ffff 0 0000 00aa
0 0 03000 0 0000 c0de
1 1 07ff6 1 0000 0000
1 0 07ff6 0 0000 0000
0 0 7f000 0 0000 c0de
0 0 7ffff 0 0000 f00d
# back to back
0 1 00100 3 0001 0000
0 1 00101 3 0002 0000
0 0 00100 0 0000 0001
0 0 00101 0 0000 0002
0 0 00010 0 0000 1234

// File: filelist.f
bus_pkg.sv
map_pkg.sv
pipe_reg.sv
mem_ram.sv
io_regs.sv
bus_exec.sv
bus_fabric_top.sv
bus_fabric_asserts.sv
tb_bus_fabric.sv

// File: io_regs.sv
`timescale 1ns/1ns

module io_regs
    import bus_pkg::*;
    import map_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 wr_en,
    input  logic [addr_w-1:0]    addr,
    input  logic [bytesel_w-1:0] bytesel,
    input  logic [data_w-1:0]    wdata,
    output logic [data_w-1:0]    rdata,
    output logic                 shadow_en
);

    logic [data_w-1:0] scratch;
    logic              is_ctrl;
    logic              is_scratch;

    assign is_ctrl    = (addr == io_ctrl_addr);
    assign is_scratch = (addr == io_scratch_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow_en <= 1'b0;
            scratch   <= '0;
        end else if (en && wr_en) begin
            if (is_ctrl && bytesel[shadow_en_bit/8])
                shadow_en <= wdata[shadow_en_bit];  // Only bit kept
            if (is_scratch) begin
                for (int i = 0; i < bytesel_w; i++) begin
                    if (bytesel[i])
                        scratch[i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= '0;  // Unmapped reads zero
            if (is_ctrl)
                rdata[shadow_en_bit] <= shadow_en;
            else if (is_scratch)
                rdata <= scratch;
        end
    end

endmodule

// File: map_pkg.sv
package map_pkg;

    // I/O registers, as word addresses
    localparam logic [18:0] io_ctrl_addr    = 19'h07ff6;  // Byte ffec
    localparam logic [18:0] io_scratch_addr = 19'h07ffe;  // Byte fffc

    // Shadow window covers the top 8 KB of memory
    localparam logic [18:0] shadow_base = 19'h7f000;  // Byte fe000
    localparam int shadow_words = 4096;
    localparam int shadow_aw    = $clog2(shadow_words);

    localparam int main_words = 16384;
    localparam int main_aw    = $clog2(main_words);

    localparam int shadow_en_bit = 0;  // In control register

endpackage

// File: mem_ram.sv
`timescale 1ns/1ns

module mem_ram
    import bus_pkg::*;
#(
    parameter int depth = 1024
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic [bytesel_w-1:0]     bytesel,
    input  logic [data_w-1:0]        wdata,
    output logic [data_w-1:0]        rdata
);

    logic [data_w-1:0] mem [depth];

    // Unwritten lanes read as zero in simulation
    initial begin
        for (int i = 0; i < depth; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (wr_en) begin
                for (int i = 0; i < bytesel_w; i++) begin
                    if (bytesel[i])
                        mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];  // Per lane
                end
            end else begin
                rdata <= mem[addr];
            end
        end
    end

endmodule

// File: pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    logic     live;  // Set one cycle after reset
    payload_t data_q;

    assign in_ready  = live && (!full || out_ready);  // Load while draining
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
            live <= 1'b0;
        end else begin
            live <= 1'b1;
            if (in_valid && in_ready)
                full <= 1'b1;
            else if (out_ready)
                full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

endmodule

// File: tb_bus_fabric.sv
`timescale 1ns/1ns

module tb_bus_fabric
    import bus_pkg::*;
();

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req_valid;
    logic                 req_ready;
    logic                 req_io;
    logic [addr_w-1:0]    req_addr;
    logic                 req_wr_en;
    logic [bytesel_w-1:0] req_bytesel;
    logic [data_w-1:0]    req_wdata;
    logic                 rsp_valid;
    logic                 rsp_ready;
    logic [data_w-1:0]    rsp_rdata;

    // Vectors as read from the data file
    logic                 v_io[$];
    logic                 v_wr[$];
    logic [addr_w-1:0]    v_addr[$];
    logic [bytesel_w-1:0] v_bs[$];
    logic [data_w-1:0]    v_wdata[$];
    logic [data_w-1:0]    v_exp[$];

    logic [data_w-1:0] exp_q[$];  // Oldest pending response at the front
    int                n_vec = 0;
    int                rsp_count = 0;
    integer            seed = 32'h2397;

    always #5 clk = ~clk;

    bus_fabric_top u_dut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_ready(req_ready), .req_io(req_io),
        .req_addr(req_addr), .req_wr_en(req_wr_en), .req_bytesel(req_bytesel),
        .req_wdata(req_wdata),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [data_w-1:0] got,
                               input logic [data_w-1:0] want);
        if (got !== want)
            fail_run($sformatf("Mismatch at %0t: %s is %h, expected %h",
                               $time, name, got, want));
    endtask

    task automatic load_vectors();
        int          fd;
        string       line;
        logic [31:0] f_io, f_wr, f_addr, f_bs, f_wdata, f_exp;
        fd = $fopen("bus_testdata.txt", "r");
        if (fd == 0)
            fail_run("Could not open bus_testdata.txt for reading");
        while ($fgets(line, fd) != 0) begin
            // Comment and blank lines do not parse
            if ($sscanf(line, "%h %h %h %h %h %h",
                        f_io, f_wr, f_addr, f_bs, f_wdata, f_exp) == 6) begin
                v_io.push_back(f_io[0]);
                v_wr.push_back(f_wr[0]);
                v_addr.push_back(f_addr[addr_w-1:0]);
                v_bs.push_back(f_bs[bytesel_w-1:0]);
                v_wdata.push_back(f_wdata[data_w-1:0]);
                v_exp.push_back(f_exp[data_w-1:0]);
            end
        end
        $fclose(fd);
        n_vec = v_exp.size();
    endtask

    task automatic drive_all();
        int gap;
        for (int i = 0; i < n_vec; i++) begin
            gap = {$random(seed)} % 3;
            if (gap != 0) begin
                req_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            req_valid   = 1'b1;
            req_io      = v_io[i];
            req_wr_en   = v_wr[i];
            req_addr    = v_addr[i];
            req_bytesel = v_bs[i];
            req_wdata   = v_wdata[i];
            exp_q.push_back(v_exp[i]);
            #1;
            while (!req_ready) begin  // Hold fields while stalled
                @(negedge clk);
                #1;
            end
            @(negedge clk);  // Taken at the rising edge just passed
        end
        req_valid = 1'b0;
    endtask

    initial begin
        rst         = 1'b1;
        req_valid   = 1'b0;
        req_io      = 1'b0;
        req_addr    = '0;
        req_wr_en   = 1'b0;
        req_bytesel = '0;
        req_wdata   = '0;
        load_vectors();
        if (n_vec == 0)
            fail_run("No vectors found in bus_testdata.txt");
        repeat (4) @(negedge clk);
        rst = 1'b0;
        drive_all();
        wait (rsp_count == n_vec);
        repeat (5) @(negedge clk);  // Room for a stray extra response
        $display("PASS: all tests");
        $finish;
    end

    // Random back-pressure with each response checked before its taking edge
    initial begin : response_monitor
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rsp_ready = ({$random(seed)} % 4) != 0;
            #1;
            if (!rst && rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("A response arrived with no request outstanding");
                end else begin
                    check_value($sformatf("rsp_rdata (response %0d)", rsp_count),
                                rsp_rdata, exp_q.pop_front());
                    rsp_count++;
                end
            end
        end
    end

    initial begin : watchdog
        wait (n_vec > 0);
        repeat (n_vec * 40 + 4) @(posedge clk);
        fail_run($sformatf("Timeout: only %0d of %0d responses arrived in time",
                           rsp_count, n_vec));
    end

endmodule
